// File: la_decode.f
+incdir+bench
src/la_decode_pkg.sv
src/id_1r_i26.sv
src/id_3r.sv
src/id_2ri12.sv
src/id_merge.sv
src/id_out_reg.sv
src/decode_stage.sv
bench/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_decode_stage -f la_decode.f \
    && ./obj_dir/Vtb_decode_stage | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

// File: bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected bundle for one word, privilege check included
function automatic dec_t model_decode(input logic [31:0] pc, input logic [31:0] inst,
                                      input logic [1:0] plv);
    dec_t        d;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [11:0] i12;
    rj  = inst[9:5];
    rd  = inst[4:0];
    i12 = inst[21:10];
    d            = '0;
    d.pc         = pc;
    d.inst       = inst;
    d.inst_valid = 1'b1;
    if (inst[31:10] inside {op_ertn, op_tlbsrch, op_tlbrd, op_tlbwr, op_tlbfill}) begin
        d.is_privilege = 1'b1;
        d.alusel       = sel_csr;
        d.reg_write_en = (inst[31:10] == op_tlbrd);  // tlbrd targets r0
        case (inst[31:10])
            op_ertn:    d.aluop = alu_ertn;
            op_tlbsrch: d.aluop = alu_tlbsrch;
            op_tlbrd:   d.aluop = alu_tlbrd;
            op_tlbwr:   d.aluop = alu_tlbwr;
            default:    d.aluop = alu_tlbfill;
        endcase
    end else if (inst[31:10] == op_rdcnt_id || inst[31:10] == op_rdcnt_vh) begin
        d.is_cnt         = 1'b1;
        d.alusel         = sel_csr;
        d.reg_write_en   = 1'b1;
        d.reg_write_addr = rd;
        if (inst[31:10] == op_rdcnt_vh) begin
            d.aluop = alu_rdcntvh;
        end else if (rj == 5'd0) begin
            d.aluop = alu_rdcntvl;
        end else begin
            d.aluop          = alu_rdcntid;  // counter id goes to rj
            d.reg_write_addr = rj;
            d.csr_read_en    = 1'b1;
        end
    end else if (inst[31:15] inside {op_add_w, op_sub_w, op_slt, op_sltu,
                                     op_and, op_or, op_xor}) begin
        d.reg1_read_en   = 1'b1;
        d.reg1_read_addr = rj;
        d.reg2_read_en   = 1'b1;
        d.reg2_read_addr = inst[14:10];
        d.reg_write_en   = 1'b1;
        d.reg_write_addr = rd;
        case (inst[31:15])
            op_add_w: d.aluop = alu_add;
            op_sub_w: d.aluop = alu_sub;
            op_slt:   d.aluop = alu_slt;
            op_sltu:  d.aluop = alu_sltu;
            op_and:   d.aluop = alu_and;
            op_or:    d.aluop = alu_or;
            default:  d.aluop = alu_xor;
        endcase
        d.alusel = (d.aluop inside {alu_and, alu_or, alu_xor}) ? sel_logic : sel_arith;
    end else if (inst[31:22] inside {op_addi_w, op_slti, op_sltui,
                                     op_andi, op_ori, op_xori}) begin
        d.reg1_read_en   = 1'b1;
        d.reg1_read_addr = rj;
        d.reg_write_en   = 1'b1;
        d.reg_write_addr = rd;
        case (inst[31:22])
            op_addi_w: d.aluop = alu_add;
            op_slti:   d.aluop = alu_slt;
            op_sltui:  d.aluop = alu_sltu;
            op_andi:   d.aluop = alu_and;
            op_ori:    d.aluop = alu_or;
            default:   d.aluop = alu_xor;
        endcase
        if (d.aluop inside {alu_and, alu_or, alu_xor}) begin
            d.alusel = sel_logic;
            d.imm    = {20'd0, i12};
        end else begin
            d.alusel = sel_arith;
            d.imm    = {{20{i12[11]}}, i12};
        end
    end else begin
        d.inst_valid   = 1'b0;  // nobody claims it
        d.is_exception = 1'b1;
        d.exc_cause    = exc_ine;
    end
    if (d.is_privilege && plv == 2'd3) begin
        d.reg_write_en = 1'b0;
        d.is_exception = 1'b1;
        d.exc_cause    = exc_ipe;
    end
    return d;
endfunction

`endif

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage;
    import la_decode_pkg::*;

    `include "decode_model.svh"

    localparam int n_insts    = 1000;
    localparam int max_cycles = 3 * n_insts;  // about 2 cycles each at half out_ready

    localparam logic [21:0] ops_1r [8] = '{op_ertn, op_tlbsrch, op_tlbrd, op_tlbwr,
                                           op_tlbfill, op_rdcnt_id, op_rdcnt_vh, op_rdcnt_id};
    localparam logic [16:0] ops_3r [8] = '{op_add_w, op_sub_w, op_slt, op_sltu,
                                           op_and, op_or, op_xor, op_add_w};
    localparam logic [9:0]  ops_2ri [8] = '{op_addi_w, op_slti, op_sltui, op_andi,
                                            op_ori, op_xori, op_addi_w, op_andi};

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    fetch_t      in;
    logic [1:0]  plv;
    logic        out_valid;
    logic        out_ready;
    dec_t        out;

    logic [31:0] lfsr = 32'haee313a3;
    dec_t        expected [$];
    dec_t        held;
    logic        stalled = 1'b0;
    logic        after_reset = 1'b0;
    logic        fire;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycles = 0;
    int          sent = 0;
    int          received = 0;

    decode_stage decode_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (in),
        .plv       (plv),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] word;
        logic [1:0]  fmt;
        fmt  = 2'(rand_bits(2));
        word = rand_bits(32);
        case (fmt)
            2'd0: begin
                word[31:10] = ops_1r[3'(rand_bits(3))];
                if (rand_bits(1) != 0) word[9:5] = 5'd0;  // reach rdcntvl
            end
            2'd1:    word[31:15] = ops_3r[3'(rand_bits(3))];
            2'd2:    word[31:22] = ops_2ri[3'(rand_bits(3))];
            default: ;  // junk word
        endcase
        return word;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t ns out.%s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bundle(input dec_t got, input dec_t exp);
        check_field("pc", got.pc, exp.pc);
        check_field("inst", got.inst, exp.inst);
        check_field("inst_valid", 32'(got.inst_valid), 32'(exp.inst_valid));
        check_field("reg_write_en", 32'(got.reg_write_en), 32'(exp.reg_write_en));
        check_field("reg_write_addr", 32'(got.reg_write_addr), 32'(exp.reg_write_addr));
        check_field("aluop", 32'(got.aluop), 32'(exp.aluop));
        check_field("alusel", 32'(got.alusel), 32'(exp.alusel));
        check_field("imm", got.imm, exp.imm);
        check_field("reg1_read_en", 32'(got.reg1_read_en), 32'(exp.reg1_read_en));
        check_field("reg1_read_addr", 32'(got.reg1_read_addr), 32'(exp.reg1_read_addr));
        check_field("reg2_read_en", 32'(got.reg2_read_en), 32'(exp.reg2_read_en));
        check_field("reg2_read_addr", 32'(got.reg2_read_addr), 32'(exp.reg2_read_addr));
        check_field("is_privilege", 32'(got.is_privilege), 32'(exp.is_privilege));
        check_field("is_cnt", 32'(got.is_cnt), 32'(exp.is_cnt));
        check_field("csr_read_en", 32'(got.csr_read_en), 32'(exp.csr_read_en));
        check_field("csr_write_en", 32'(got.csr_write_en), 32'(exp.csr_write_en));
        check_field("csr_addr", 32'(got.csr_addr), 32'(exp.csr_addr));
        check_field("invtlb_op", 32'(got.invtlb_op), 32'(exp.invtlb_op));
        check_field("is_exception", 32'(got.is_exception), 32'(exp.is_exception));
        check_field("exc_cause", 32'(got.exc_cause), 32'(exp.exc_cause));
    endtask

    // sampled mid-cycle, inputs move only just after posedge
    always @(negedge clk) begin
        if (reset || after_reset) begin
            assert (!out_valid && out === '0) else begin
                value_errors++;
                $display("[FAIL] %0t ns out_valid/out got %b/%h expected 0/0", $time,
                         out_valid, out);
            end
        end
        if (stalled) begin
            assert (out_valid && out === held) else begin
                value_errors++;
                $display("[FAIL] %0t ns out got %b/%h expected 1/%h", $time, out_valid, out, held);
            end
        end
        if (!reset) begin
            // one-entry register, so pending work means a full slot
            assert (out_valid === (expected.size() != 0)) else begin
                value_errors++;
                $display("[FAIL] %0t ns out_valid got %b expected %b", $time, out_valid,
                         expected.size() != 0);
            end
            assert (in_ready === (expected.size() == 0 || out_ready)) else begin
                value_errors++;
                $display("[FAIL] %0t ns in_ready got %b expected %b", $time, in_ready,
                         expected.size() == 0 || out_ready);
            end
            if (out_valid && out_ready) begin
                assert (expected.size() != 0) else begin
                    protocol_errors++;
                    $display("output at %0t ns with no instruction pending", $time);
                end
                if (expected.size() != 0) compare_bundle(out, expected.pop_front());
                received++;
            end
            if (in_valid && in_ready) expected.push_back(model_decode(in.pc, in.inst, plv));
        end
        stalled     = out_valid && !out_ready && !reset;
        held        = out;
        after_reset = reset;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d instructions seen",
                     cycles, received, n_insts);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in        = '0;
        plv       = 2'd0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset     = 1'b0;
        in_valid  = 1'b1;
        in.pc     = 32'h1c000000;
        in.inst   = random_inst();
        plv       = 2'(rand_bits(2));
        out_ready = 1'(rand_bits(1));
        while (sent < n_insts) begin
            @(negedge clk);
            fire = in_valid && in_ready;
            @(posedge clk);
            #1;
            out_ready = 1'(rand_bits(1));
            if (fire) begin
                sent++;
                if (sent < n_insts) begin
                    in.pc   = 32'h1c000000 + sent * 4;
                    in.inst = random_inst();
                    plv     = 2'(rand_bits(2));
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
        out_ready = 1'b1;
        while (out_valid || expected.size() != 0) @(negedge clk);
        $display("value errors: %0d, protocol errors: %0d, instructions checked: %0d",
                 value_errors, protocol_errors, received);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  la_decode_pkg::fetch_t in,
    input  logic [1:0]            plv,
    output logic                  out_valid,
    input  logic                  out_ready,
    output la_decode_pkg::dec_t   out
);
    import la_decode_pkg::*;

    dec_t dec_1r;
    dec_t dec_3r;
    dec_t dec_2ri;
    dec_t dec_sel;

    id_1r_i26 u_id_1r_i26 (.inst(in.inst), .pc(in.pc), .dec(dec_1r));
    id_3r     u_id_3r     (.inst(in.inst), .pc(in.pc), .dec(dec_3r));
    id_2ri12  u_id_2ri12  (.inst(in.inst), .pc(in.pc), .dec(dec_2ri));

    id_merge u_id_merge (
        .dec_1r  (dec_1r),
        .dec_3r  (dec_3r),
        .dec_2ri (dec_2ri),
        .plv     (plv),
        .dec     (dec_sel)
    );

    id_out_reg u_id_out_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in        (dec_sel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: src/id_out_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_out_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  la_decode_pkg::dec_t in,
    output logic                out_valid,
    input  logic                out_ready,
    output la_decode_pkg::dec_t out
);

    // slot frees up in the same cycle it drains
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (in_valid && in_ready) begin
            out <= in;  // load on accept only
        end
    end

endmodule

`default_nettype wire

// File: src/id_merge.sv
`timescale 1ns/1ns
`default_nettype none

module id_merge (
    input  la_decode_pkg::dec_t dec_1r,
    input  la_decode_pkg::dec_t dec_3r,
    input  la_decode_pkg::dec_t dec_2ri,
    input  logic [1:0]          plv,
    output la_decode_pkg::dec_t dec
);
    import la_decode_pkg::*;

    always_comb begin
        if (dec_1r.inst_valid) begin
            dec = dec_1r;
        end else if (dec_3r.inst_valid) begin
            dec = dec_3r;
        end else if (dec_2ri.inst_valid) begin
            dec = dec_2ri;
        end else begin
            dec              = '0;  // all enables off
            dec.pc           = dec_1r.pc;
            dec.inst         = dec_1r.inst;
            dec.is_exception = 1'b1;
            dec.exc_cause    = exc_ine;
        end

        // privileged op from user mode
        if (dec.is_privilege && plv == plv_user) begin
            dec.reg_write_en = 1'b0;
            dec.is_exception = 1'b1;
            dec.exc_cause    = exc_ipe;
        end
    end

endmodule

`default_nettype wire

// File: src/id_2ri12.sv
`timescale 1ns/1ns
`default_nettype none

module id_2ri12 (
    input  logic [31:0]         inst,
    input  logic [31:0]         pc,
    output la_decode_pkg::dec_t dec
);
    import la_decode_pkg::*;

    logic [9:0]  opcode;
    logic [11:0] imm12;
    logic [4:0]  rj;
    logic [4:0]  rd;

    assign opcode = inst[31:22];
    assign imm12  = inst[21:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    always_comb begin
        dec            = '0;
        dec.pc         = pc;
        dec.inst       = inst;
        dec.aluop      = alu_nop;
        dec.alusel     = sel_nop;
        dec.exc_cause  = exc_none;
        dec.inst_valid = 1'b1;
        case (opcode)
            op_addi_w: begin dec.aluop = alu_add;  dec.alusel = sel_arith; end
            op_slti:   begin dec.aluop = alu_slt;  dec.alusel = sel_arith; end
            op_sltui:  begin dec.aluop = alu_sltu; dec.alusel = sel_arith; end
            op_andi:   begin dec.aluop = alu_and;  dec.alusel = sel_logic; end
            op_ori:    begin dec.aluop = alu_or;   dec.alusel = sel_logic; end
            op_xori:   begin dec.aluop = alu_xor;  dec.alusel = sel_logic; end
            default:   dec.inst_valid = 1'b0;
        endcase
        if (dec.inst_valid) begin
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
            // logic ops take ui12, arith ops take si12
            if (dec.alusel == sel_logic) dec.imm = {20'd0, imm12};
            else                         dec.imm = {{20{imm12[11]}}, imm12};
        end
    end

endmodule

`default_nettype wire

// File: src/id_3r.sv
`timescale 1ns/1ns
`default_nettype none

module id_3r (
    input  logic [31:0]         inst,
    input  logic [31:0]         pc,
    output la_decode_pkg::dec_t dec
);
    import la_decode_pkg::*;

    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic        hit;
    alu_op_e     op;
    alu_sel_e    sel;

    assign opcode = inst[31:15];
    assign rk     = inst[14:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    always_comb begin
        hit = 1'b1;
        op  = alu_nop;
        sel = sel_nop;
        case (opcode)
            op_add_w: begin op = alu_add;  sel = sel_arith; end
            op_sub_w: begin op = alu_sub;  sel = sel_arith; end
            op_slt:   begin op = alu_slt;  sel = sel_arith; end
            op_sltu:  begin op = alu_sltu; sel = sel_arith; end
            op_and:   begin op = alu_and;  sel = sel_logic; end
            op_or:    begin op = alu_or;   sel = sel_logic; end
            op_xor:   begin op = alu_xor;  sel = sel_logic; end
            default:  hit = 1'b0;
        endcase
    end

    always_comb begin
        dec                = '0;
        dec.pc             = pc;
        dec.inst           = inst;
        dec.exc_cause      = exc_none;
        dec.inst_valid     = hit;
        dec.aluop          = op;
        dec.alusel         = sel;
        dec.reg1_read_en   = hit;
        dec.reg1_read_addr = hit ? rj : 5'd0;
        dec.reg2_read_en   = hit;
        dec.reg2_read_addr = hit ? rk : 5'd0;
        dec.reg_write_en   = hit;
        dec.reg_write_addr = hit ? rd : 5'd0;
    end

endmodule

`default_nettype wire

// File: src/id_1r_i26.sv
`timescale 1ns/1ns
`default_nettype none

module id_1r_i26 (
    input  logic [31:0]         inst,
    input  logic [31:0]         pc,
    output la_decode_pkg::dec_t dec
);
    import la_decode_pkg::*;

    logic [21:0] opcode;
    logic [4:0]  rj;
    logic [4:0]  rd;

    assign opcode = inst[31:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    always_comb begin
        dec           = '0;
        dec.pc        = pc;
        dec.inst      = inst;
        dec.aluop     = alu_nop;
        dec.alusel    = sel_nop;
        dec.exc_cause = exc_none;
        case (opcode)
            op_ertn: begin
                dec.inst_valid   = 1'b1;
                dec.is_privilege = 1'b1;
                dec.aluop        = alu_ertn;
                dec.alusel       = sel_csr;
            end
            op_tlbsrch: begin
                dec.inst_valid   = 1'b1;
                dec.is_privilege = 1'b1;
                dec.aluop        = alu_tlbsrch;
                dec.alusel       = sel_csr;
            end
            op_tlbrd: begin
                dec.inst_valid   = 1'b1;
                dec.is_privilege = 1'b1;
                dec.reg_write_en = 1'b1;  // write address stays 0
                dec.aluop        = alu_tlbrd;
                dec.alusel       = sel_csr;
            end
            op_tlbwr: begin
                dec.inst_valid   = 1'b1;
                dec.is_privilege = 1'b1;
                dec.aluop        = alu_tlbwr;
                dec.alusel       = sel_csr;
            end
            op_tlbfill: begin
                dec.inst_valid   = 1'b1;
                dec.is_privilege = 1'b1;
                dec.aluop        = alu_tlbfill;
                dec.alusel       = sel_csr;
            end
            op_rdcnt_id: begin
                dec.inst_valid   = 1'b1;
                dec.is_cnt       = 1'b1;
                dec.reg_write_en = 1'b1;
                dec.alusel       = sel_csr;
                if (rj != 5'd0) begin  // rdcntid.w writes rj
                    dec.aluop          = alu_rdcntid;
                    dec.reg_write_addr = rj;
                    dec.csr_read_en    = 1'b1;
                end else begin
                    dec.aluop          = alu_rdcntvl;
                    dec.reg_write_addr = rd;
                end
            end
            op_rdcnt_vh: begin
                dec.inst_valid     = 1'b1;
                dec.is_cnt         = 1'b1;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.aluop          = alu_rdcntvh;
                dec.alusel         = sel_csr;
            end
            default: ;  // not ours
        endcase
    end

endmodule

`default_nettype wire

// File: src/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

    typedef enum logic [7:0] {
        alu_nop     = 8'h00,
        alu_add     = 8'h01,
        alu_sub     = 8'h02,
        alu_slt     = 8'h03,
        alu_sltu    = 8'h04,
        alu_and     = 8'h05,
        alu_or      = 8'h06,
        alu_xor     = 8'h07,
        alu_ertn    = 8'h10,  // exception return
        alu_rdcntid = 8'h11,
        alu_rdcntvl = 8'h12,
        alu_rdcntvh = 8'h13,
        alu_tlbsrch = 8'h20,
        alu_tlbrd   = 8'h21,
        alu_tlbwr   = 8'h22,
        alu_tlbfill = 8'h23
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_nop   = 3'd0,
        sel_arith = 3'd1,
        sel_logic = 3'd2,
        sel_csr   = 3'd3
    } alu_sel_e;

    typedef enum logic [6:0] {
        exc_none = 7'h00,
        exc_ine  = 7'h0d,  // instruction not existing
        exc_ipe  = 7'h0e   // privilege error
    } exc_cause_e;

    // 1R / I26 formats, inst[31:10]
    localparam logic [21:0] op_ertn     = 22'h1920e;
    localparam logic [21:0] op_tlbsrch  = 22'h1920a;
    localparam logic [21:0] op_tlbrd    = 22'h1920b;
    localparam logic [21:0] op_tlbwr    = 22'h1920c;
    localparam logic [21:0] op_tlbfill  = 22'h1920d;
    localparam logic [21:0] op_rdcnt_id = 22'h00018;  // rdcntid.w / rdcntvl.w
    localparam logic [21:0] op_rdcnt_vh = 22'h00019;

    // 3R, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12, inst[31:22]
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;

    localparam logic [1:0] plv_user = 2'd3;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        inst_valid;  // decoder claims the word
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        alu_op_e     aluop;
        alu_sel_e    alusel;
        logic [31:0] imm;
        logic        reg1_read_en;
        logic [4:0]  reg1_read_addr;
        logic        reg2_read_en;
        logic [4:0]  reg2_read_addr;
        logic        is_privilege;
        logic        is_cnt;
        logic        csr_read_en;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        logic [4:0]  invtlb_op;
        logic        is_exception;
        exc_cause_e  exc_cause;
    } dec_t;

endpackage

`default_nettype wire
